//--- subsys_defs.svh
`ifndef SUBSYS_DEFS_SVH
`define SUBSYS_DEFS_SVH

// Widths shared by the AXI slaves and the RAM
// The subsystem is fixed-size, so every module reads these directly

// AXI4-Lite data bus, one 32-bit word per beat
`define AXI_DATA_WIDTH 32

// AXI4-Lite byte address
`define AXI_ADDR_WIDTH 32

// RAM word address, 1024 words deep
`define BRAM_ADDR_WIDTH 10

// Byte-offset bits below the word address
`define ADDR_LSB 2

// Upper address bits above ADDR_LSB + BRAM_ADDR_WIDTH are ignored,
// so accesses beyond the RAM depth wrap onto the low words

`endif

//--- axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

  // AXI response codes as carried on bresp and rresp
  typedef enum logic [1:0]
  {
    RESP_OKAY   = 2'b00, // Normal access done
    RESP_EXOKAY = 2'b01, // Exclusive access done
    RESP_SLVERR = 2'b10, // Slave error
    RESP_DECERR = 2'b11  // Decode error
  } resp_t;

  // Only RESP_OKAY is returned by this subsystem.
  // The other codes are kept so the type covers the full bus encoding

endpackage

`default_nettype wire

//--- bram_pkg.sv
`default_nettype none

`include "subsys_defs.svh"

package bram_pkg;

  // Byte enable, one bit per byte lane
  typedef logic [`AXI_DATA_WIDTH/8-1:0] strb_t;

  // RAM word address
  typedef logic [`BRAM_ADDR_WIDTH-1:0] addr_t;

  // One RAM word, seen either whole or as byte lanes
  typedef union packed
  {
    logic [`AXI_DATA_WIDTH-1:0]        word;  // Whole word, AXI side
    logic [`AXI_DATA_WIDTH/8-1:0][7:0] bytes; // Byte lanes, strobe merge
  } word_u;

endpackage

`default_nettype wire

//--- bram_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bram_port_if;

  logic              en;     // Port enable
  bram_pkg::addr_t   addr;   // Word address
  bram_pkg::word_u   wrdata; // Write data
  bram_pkg::strb_t   we;     // Byte write enables
  bram_pkg::word_u   rddata; // Registered read data

  // AXI slave side, issues the accesses
  modport master
  (
    output en,
    output addr,
    output wrdata,
    output we,
    input  rddata
  );

  // RAM side, serves the accesses
  modport slave
  (
    input  en,
    input  addr,
    input  wrdata,
    input  we,
    output rddata
  );

endinterface

`default_nettype wire

//--- axi_bram_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "subsys_defs.svh"

module axi_bram_writer
(
  input  wire                       aclk,
  input  wire                       aresetn,

  input  wire [`AXI_ADDR_WIDTH-1:0] s_axi_awaddr,  // Byte address
  input  wire                       s_axi_awvalid,
  output logic                      s_axi_awready,
  input  wire [`AXI_DATA_WIDTH-1:0] s_axi_wdata,
  input  bram_pkg::strb_t           s_axi_wstrb,
  input  wire                       s_axi_wvalid,
  output logic                      s_axi_wready,
  output axi_lite_pkg::resp_t       s_axi_bresp,
  output logic                      s_axi_bvalid,
  input  wire                       s_axi_bready,

  bram_port_if.master               bram           // RAM port A
);

  logic wready_q, wready_d; // One-cycle ready pulse for AW and W
  logic bvalid_q, bvalid_d; // Held write response
  logic wr_fire;            // Both channels valid and writer idle

  // A new write starts only when no pulse or response is outstanding
  assign wr_fire = s_axi_awvalid & s_axi_wvalid & ~wready_q & ~bvalid_q;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wready_q <= 1'b0;
      bvalid_q <= 1'b0;
    end
    else
    begin
      wready_q <= wready_d;
      bvalid_q <= bvalid_d;
    end
  end

  always_comb
  begin
    wready_d = wready_q;
    bvalid_d = bvalid_q;

    if (wr_fire)
    begin
      wready_d = 1'b1; // RAM takes the word on this edge
    end

    if (wready_q)
    begin
      wready_d = 1'b0; // Handshake done, response follows
      bvalid_d = 1'b1;
    end

    if (s_axi_bready & bvalid_q)
    begin
      bvalid_d = 1'b0; // Response taken
    end
  end

  assign s_axi_awready = wready_q;
  assign s_axi_wready  = wready_q;
  assign s_axi_bvalid  = bvalid_q;
  assign s_axi_bresp   = axi_lite_pkg::RESP_OKAY; // Every write succeeds

  // Drop the byte offset; bits above the RAM depth are ignored
  assign bram.en          = wr_fire;
  assign bram.addr        = s_axi_awaddr[`ADDR_LSB +: `BRAM_ADDR_WIDTH];
  assign bram.wrdata.word = s_axi_wdata;
  assign bram.we          = wr_fire ? s_axi_wstrb : '0; // Strobes only while writing

endmodule

`default_nettype wire

//--- bram_dual_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "subsys_defs.svh"

module bram_dual_port
(
  input  wire        aclk,

  bram_port_if.slave port_a, // Byte-enabled write port
  bram_port_if.slave port_b  // Registered read port
);

  localparam int DEPTH = 1 << `BRAM_ADDR_WIDTH;
  localparam int NUM_BYTES = `AXI_DATA_WIDTH / 8;

  bram_pkg::word_u mem [0:DEPTH-1]; // Contents are not reset
  bram_pkg::word_u rd_word;         // Port B output register

  // Port A write, each strobed byte lane is merged on its own
  always_ff @(posedge aclk)
  begin
    if (port_a.en)
    begin
      for (int i = 0; i < NUM_BYTES; i++)
      begin
        if (port_a.we[i])
        begin
          mem[port_a.addr].bytes[i] <= port_a.wrdata.bytes[i];
        end
      end
    end
  end

  // Port B read, output holds until the next enabled read
  always_ff @(posedge aclk)
  begin
    if (port_b.en)
    begin
      rd_word <= mem[port_b.addr];
    end
  end

  assign port_b.rddata = rd_word;
  assign port_a.rddata = '0; // Write-only port

endmodule

`default_nettype wire

//--- axi_bram_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "subsys_defs.svh"

module axi_bram_reader
(
  input  wire                       aclk,
  input  wire                       aresetn,

  input  wire [`AXI_ADDR_WIDTH-1:0] s_axi_araddr,  // Byte address
  input  wire                       s_axi_arvalid,
  output logic                      s_axi_arready,
  output logic [`AXI_DATA_WIDTH-1:0] s_axi_rdata,
  output axi_lite_pkg::resp_t       s_axi_rresp,
  output logic                      s_axi_rvalid,
  input  wire                       s_axi_rready,

  bram_port_if.master               bram           // RAM port B
);

  logic arready_q, arready_d; // One-cycle address accept pulse
  logic rvalid_q, rvalid_d;   // Held read response

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end
    else
    begin
      arready_q <= arready_d;
      rvalid_q  <= rvalid_d;
    end
  end

  always_comb
  begin
    arready_d = arready_q;
    rvalid_d  = rvalid_q;

    // Only one read in flight; a held response blocks the next address
    if (s_axi_arvalid & ~arready_q & ~rvalid_q)
    begin
      arready_d = 1'b1;
    end

    if (arready_q)
    begin
      arready_d = 1'b0;
      rvalid_d  = 1'b1; // RAM word is registered on this edge
    end

    if (s_axi_rready & rvalid_q)
    begin
      rvalid_d = 1'b0; // Response taken
    end
  end

  assign s_axi_arready = arready_q;
  assign s_axi_rvalid  = rvalid_q;
  assign s_axi_rresp   = axi_lite_pkg::RESP_OKAY;

  // RAM output register holds the word while rvalid waits for rready
  assign s_axi_rdata = bram.rddata.word;

  // Read access is issued in the arready cycle, address is still valid then
  assign bram.en     = arready_q;
  assign bram.addr   = s_axi_araddr[`ADDR_LSB +: `BRAM_ADDR_WIDTH];
  assign bram.wrdata = '0;
  assign bram.we     = '0; // Read-only port

endmodule

`default_nettype wire

//--- axi_bram_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "subsys_defs.svh"

module axi_bram_subsystem
(
  input  wire                        aclk,
  input  wire                        aresetn,

  // Write slave
  input  wire [`AXI_ADDR_WIDTH-1:0]  s_axi_awaddr,
  input  wire                        s_axi_awvalid,
  output logic                       s_axi_awready,
  input  wire [`AXI_DATA_WIDTH-1:0]  s_axi_wdata,
  input  wire [`AXI_DATA_WIDTH/8-1:0] s_axi_wstrb,
  input  wire                        s_axi_wvalid,
  output logic                       s_axi_wready,
  output logic [1:0]                 s_axi_bresp,
  output logic                       s_axi_bvalid,
  input  wire                        s_axi_bready,

  // Read slave
  input  wire [`AXI_ADDR_WIDTH-1:0]  s_axi_araddr,
  input  wire                        s_axi_arvalid,
  output logic                       s_axi_arready,
  output logic [`AXI_DATA_WIDTH-1:0] s_axi_rdata,
  output logic [1:0]                 s_axi_rresp,
  output logic                       s_axi_rvalid,
  input  wire                        s_axi_rready
);

  bram_port_if port_a (); // Writer to RAM
  bram_port_if port_b (); // Reader to RAM

  axi_bram_writer u_writer
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .bram          (port_a.master)
  );

  bram_dual_port u_bram
  (
    .aclk   (aclk),
    .port_a (port_a.slave),
    .port_b (port_b.slave)
  );

  axi_bram_reader u_reader
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .bram          (port_b.master)
  );

endmodule

`default_nettype wire

//--- tb_axi_bram_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "subsys_defs.svh"

module tb_axi_bram_subsystem;

  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 5;
  localparam int DEPTH          = 1 << `BRAM_ADDR_WIDTH;
  localparam int BYTE_SPAN      = DEPTH * 4;  // Bytes covered by the RAM
  localparam int N_FULL         = 16;         // Full-word write and read pairs
  localparam int N_PART         = 8;          // Full write, partial write, read
  localparam int N_ALIAS        = 4;
  localparam int N_MIX          = 200;
  localparam int MIX_WORDS      = 32;         // Word window of the random mix
  localparam int MIX_BASE       = 'h800;
  localparam int NUM_TRANS      = 2*N_FULL + 3*N_PART + 2*N_ALIAS + 3 + MIX_WORDS + N_MIX;
  localparam int TIMEOUT_CYCLES = NUM_TRANS * 20 + RESET_CYCLES;

  logic                        aclk;
  logic                        aresetn;
  logic [`AXI_ADDR_WIDTH-1:0]  s_axi_awaddr;
  logic                        s_axi_awvalid;
  logic                        s_axi_awready;
  logic [`AXI_DATA_WIDTH-1:0]  s_axi_wdata;
  logic [`AXI_DATA_WIDTH/8-1:0] s_axi_wstrb;
  logic                        s_axi_wvalid;
  logic                        s_axi_wready;
  logic [1:0]                  s_axi_bresp;
  logic                        s_axi_bvalid;
  logic                        s_axi_bready;
  logic [`AXI_ADDR_WIDTH-1:0]  s_axi_araddr;
  logic                        s_axi_arvalid;
  logic                        s_axi_arready;
  logic [`AXI_DATA_WIDTH-1:0]  s_axi_rdata;
  logic [1:0]                  s_axi_rresp;
  logic                        s_axi_rvalid;
  logic                        s_axi_rready;

  integer                     seed = 18090;
  logic [`AXI_DATA_WIDTH-1:0] ref_mem [0:DEPTH-1]; // Reference RAM
  logic [`AXI_DATA_WIDTH-1:0] expect_q [$];        // Expected words of accepted reads
  logic [`AXI_DATA_WIDTH-1:0] exp_word;
  string                      cur_test;
  int                         errors = 0;
  int                         test_start_errors = 0;
  int                         pass_count = 0;
  int                         fail_count = 0;

  axi_bram_subsystem uut
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready)
  );

  initial
  begin
    aclk = 1'b0;
    forever #(CLK_PERIOD/2) aclk = ~aclk;
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge aclk);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // Expected word after a strobed write over the old word
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] merged;
    merged = old_word;
    for (int i = 0; i < 4; i++)
    begin
      if (strb[i])
      begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

  function automatic int word_index(input logic [31:0] addr);
    return (addr >> 2) % DEPTH; // Upper bits wrap onto the RAM depth
  endfunction

  // Every accepted read response is compared here
  always @(posedge aclk)
  begin
    if (s_axi_rvalid && s_axi_rready)
    begin
      assert (expect_q.size() != 0)
      else
      begin
        $display("%s: read response arrived with no read outstanding", cur_test);
        errors++;
      end
      if (expect_q.size() != 0)
      begin
        exp_word = expect_q.pop_front();
        assert (s_axi_rdata === exp_word)
        else
        begin
          $display("Mismatch in %s: expected %h, actual %h", cur_test, exp_word, s_axi_rdata);
          errors++;
        end
      end
      assert (s_axi_rresp == axi_lite_pkg::RESP_OKAY)
      else
      begin
        $display("%s: read response was not OKAY (rresp %b)", cur_test, s_axi_rresp);
        errors++;
      end
    end
  end

  task automatic reset_dut();
    aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_start_errors = errors;
  endtask

  task automatic finish_test();
    if (errors == test_start_errors)
    begin
      pass_count++;
      $display("Test %s: passed", cur_test);
    end
    else
    begin
      fail_count++;
      $display("Test %s: failed with %0d errors", cur_test, errors - test_start_errors);
    end
  endtask

  // Write one word, holding bready low for bready_delay cycles after bvalid
  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int bready_delay);
    int idx;
    idx = word_index(addr);
    @(negedge aclk);
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    do @(posedge aclk); while (!s_axi_awready);
    assert (s_axi_wready)
    else
    begin
      $display("%s: awready and wready did not rise together", cur_test);
      errors++;
    end
    @(negedge aclk);
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    do @(posedge aclk); while (!s_axi_bvalid);
    repeat (bready_delay)
    begin
      @(posedge aclk);
      assert (s_axi_bvalid)
      else
      begin
        $display("%s: bvalid dropped while bready was low", cur_test);
        errors++;
      end
    end
    @(negedge aclk);
    s_axi_bready = 1'b1;
    @(posedge aclk);
    assert (s_axi_bvalid && s_axi_bresp == axi_lite_pkg::RESP_OKAY)
    else
    begin
      $display("%s: write response missing or not OKAY (bresp %b)", cur_test, s_axi_bresp);
      errors++;
    end
    @(negedge aclk);
    s_axi_bready = 1'b0;
    ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
  endtask

  // Address phase of a read; the expected word is queued on acceptance
  task automatic read_request(input logic [31:0] addr);
    @(negedge aclk);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    do @(posedge aclk); while (!s_axi_arready);
    expect_q.push_back(ref_mem[word_index(addr)]);
    @(negedge aclk);
    s_axi_arvalid = 1'b0;
  endtask

  // Data phase, rready held low for rready_delay cycles after rvalid
  task automatic read_response(input int rready_delay);
    do @(posedge aclk); while (!s_axi_rvalid);
    repeat (rready_delay)
    begin
      @(posedge aclk);
      assert (s_axi_rvalid)
      else
      begin
        $display("%s: rvalid dropped while rready was low", cur_test);
        errors++;
      end
      // Stalled word must keep matching the model
      assert (s_axi_rdata === expect_q[0])
      else
      begin
        $display("Mismatch in %s: expected %h, actual %h", cur_test, expect_q[0], s_axi_rdata);
        errors++;
      end
      assert (!s_axi_arready)
      else
      begin
        $display("%s: arready rose while a read response was pending", cur_test);
        errors++;
      end
    end
    @(negedge aclk);
    s_axi_rready = 1'b1;
    @(posedge aclk);
    @(negedge aclk);
    s_axi_rready = 1'b0;
  endtask

  task automatic read_word(input logic [31:0] addr, input int rready_delay);
    read_request(addr);
    read_response(rready_delay);
  endtask

  initial
  begin
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] r;
    logic [31:0] addrs [N_FULL];

    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    reset_dut();

    start_test("reset_values");
    assert (!s_axi_awready && !s_axi_wready && !s_axi_bvalid && !s_axi_arready && !s_axi_rvalid)
    else
    begin
      $display("%s: a ready or valid output is high after reset", cur_test);
      errors++;
    end
    finish_test();

    start_test("full_word");
    for (int i = 0; i < N_FULL; i++)
    begin
      addrs[i] = $random(seed) & 32'hffff_fffc;
      write_word(addrs[i], $random(seed), 4'hf, 0);
    end
    for (int i = 0; i < N_FULL; i++)
    begin
      read_word(addrs[i], 0);
    end
    finish_test();

    start_test("partial_strobe");
    for (int i = 0; i < N_PART; i++)
    begin
      addr = ($unsigned($random(seed)) % DEPTH) * 4;
      r    = $random(seed);
      write_word(addr, $random(seed), 4'hf, 0);
      write_word(addr, $random(seed), r[3:0], 0);
      read_word(addr, 0);
    end
    finish_test();

    start_test("address_alias");
    for (int i = 0; i < N_ALIAS; i++)
    begin
      addr = ($unsigned($random(seed)) % DEPTH) * 4;
      data = (1 + $unsigned($random(seed)) % 7) * BYTE_SPAN; // At or above 4096
      write_word(addr + data, $random(seed), 4'hf, 0);
      read_word(addr, 0);
    end
    finish_test();

    start_test("back_pressure");
    write_word(32'h40, 32'hcafe_f00d, 4'hf, 6);
    read_request(32'h40);
    s_axi_araddr  = 32'h40; // Second read waits behind the stalled response
    s_axi_arvalid = 1'b1;
    read_response(8);
    read_word(32'h40, 0);
    finish_test();

    start_test("random_mix");
    for (int i = 0; i < MIX_WORDS; i++)
    begin
      write_word(MIX_BASE + i*4, $random(seed), 4'hf, 0);
    end
    for (int i = 0; i < N_MIX; i++)
    begin
      r    = $random(seed);
      addr = MIX_BASE + ($unsigned($random(seed)) % MIX_WORDS) * 4;
      if (r[0])
      begin
        write_word(addr, $random(seed), r[7:4], r[9:8]);
      end
      else
      begin
        read_word(addr, r[9:8]);
      end
    end
    finish_test();

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && errors == 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
axi_lite_pkg.sv
bram_pkg.sv
bram_port_if.sv
axi_bram_writer.sv
bram_dual_port.sv
axi_bram_reader.sv
axi_bram_subsystem.sv
tb_axi_bram_subsystem.sv
